/* rtl/chaseConfig.sv */
// Run-time pace settings for the chase
// cfgAddr 0 writes the frame divider, 1 writes the step size
// A divider of 0 is stored as 1, a step of 0 freezes the enemies

module chaseConfig (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      cfgWrite,
    input  logic                      cfgAddr,
    input  logic [enemyPkg::cfgW-1:0] cfgData,
    output logic [enemyPkg::cfgW-1:0] divider,
    output logic [enemyPkg::cfgW-1:0] stepSize
);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            divider <= enemyPkg::divReset;
            stepSize <= enemyPkg::stepReset;
        end else if (cfgWrite) begin
            if (cfgAddr) begin
                stepSize <= cfgData;
            end else if (cfgData == '0) begin
                divider <= 8'd1;          // Never divide by zero
            end else begin
                divider <= cfgData;
            end
        end
    end

endmodule

/* rtl/enemyChaser.sv */
// One enemy chasing the player, one axis step per move tick
// X is closed first, then Y; the box stops at the screen edge
// Left and up steps larger than the distance to 0 wrap around

module enemyChaser #(
    parameter int id = 0
) (
    input  logic                        Clk,
    input  logic                        arstN,
    input  logic                        moveTick,
    input  logic [enemyPkg::coordW-1:0] playerX,
    input  logic [enemyPkg::coordW-1:0] playerY,
    input  logic [enemyPkg::cfgW-1:0]   stepSize,
    enemyStateIf.owner                  state
);

    logic [enemyPkg::coordW-1:0] xPos;
    logic [enemyPkg::coordW-1:0] yPos;
    logic [enemyPkg::coordW-1:0] xNext;
    logic [enemyPkg::coordW-1:0] yNext;
    logic [enemyPkg::coordW-1:0] stepExt;
    enemyPkg::dir_t dir;
    enemyPkg::dir_t dirNext;
    logic moved;                                    // Step actually taken
    logic [1:0] step;

    assign stepExt = {1'b0, stepSize};

    // Chase decision, first matching rule wins
    always_comb begin
        xNext = xPos;
        yNext = yPos;
        dirNext = dir;
        moved = 1'b0;
        if (xPos < playerX) begin
            dirNext = enemyPkg::dirRight;
            if (xPos + enemyPkg::spriteW < enemyPkg::xMax) begin
                xNext = xPos + stepExt;
                moved = 1'b1;
            end
        end else if (xPos > playerX) begin
            dirNext = enemyPkg::dirLeft;
            if (xPos > enemyPkg::xMin) begin
                xNext = xPos - stepExt;
                moved = 1'b1;
            end
        end else if (yPos < playerY) begin
            dirNext = enemyPkg::dirDown;
            if (yPos + enemyPkg::spriteH < enemyPkg::yMax) begin
                yNext = yPos + stepExt;
                moved = 1'b1;
            end
        end else if (yPos > playerY) begin
            dirNext = enemyPkg::dirUp;
            if (yPos > enemyPkg::yMin) begin
                yNext = yPos - stepExt;
                moved = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            xPos <= enemyPkg::startX(id);
            yPos <= enemyPkg::startY(id);
            dir <= enemyPkg::dirDown;
        end else if (moveTick) begin
            xPos <= xNext;
            yPos <= yNext;
            dir <= dirNext;
        end
    end

    walkAnimator walk (
        .Clk     (Clk),
        .arstN   (arstN),
        .moveTick(moveTick),
        .moved   (moved),
        .step    (step)
    );

    assign state.xPos = xPos;
    assign state.yPos = yPos;
    assign state.dir = dir;
    assign state.step = step;

endmodule

/* rtl/enemyField.sv */
// Top level of the enemy subsystem, 1 to 3 enemies
// All inputs are synchronous to Clk except frameClk
// objAddress indexes a 12-frame sprite memory outside this block

module enemyField #(
    parameter int numEnemies = 3
) (
    input  logic                        Clk,
    input  logic                        arstN,
    input  logic                        frameClk,
    input  logic [enemyPkg::coordW-1:0] playerX,
    input  logic [enemyPkg::coordW-1:0] playerY,
    input  logic [enemyPkg::coordW-1:0] pixelX,
    input  logic [enemyPkg::coordW-1:0] pixelY,
    input  logic                        cfgWrite,
    input  logic                        cfgAddr,
    input  logic [enemyPkg::cfgW-1:0]   cfgData,
    output logic                        isObj,
    output logic [1:0]                  objIndex,
    output logic [enemyPkg::addrW-1:0]  objAddress
);

    logic [enemyPkg::cfgW-1:0] divider;
    logic [enemyPkg::cfgW-1:0] stepSize;
    logic moveTick;

    enemyStateIf enemyState [numEnemies] ();

    chaseConfig config0 (
        .Clk     (Clk),
        .arstN   (arstN),
        .cfgWrite(cfgWrite),
        .cfgAddr (cfgAddr),
        .cfgData (cfgData),
        .divider (divider),
        .stepSize(stepSize)
    );

    frameTick tick (
        .Clk     (Clk),
        .arstN   (arstN),
        .frameClk(frameClk),
        .divider (divider),
        .moveTick(moveTick)
    );

    for (genvar i = 0; i < numEnemies; i++) begin : chasers
        enemyChaser #(.id(i)) chaser (
            .Clk     (Clk),
            .arstN   (arstN),
            .moveTick(moveTick),
            .playerX (playerX),
            .playerY (playerY),
            .stepSize(stepSize),
            .state   (enemyState[i])
        );
    end

    spriteRender #(.numEnemies(numEnemies)) render (
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .states    (enemyState),
        .isObj     (isObj),
        .objIndex  (objIndex),
        .objAddress(objAddress)
    );

endmodule

/* rtl/enemyPkg.sv */
// Shared constants and types for the enemy subsystem
// Screen is 320x240 with the origin at the top left, sprites are 26x26
// Sprite memory holds 12 frames, 3 per facing direction

package enemyPkg;

    localparam int coordW = 9;                       // Screen coordinate width
    localparam int addrW = 13;                       // Sprite memory address width
    localparam int cfgW = 8;                         // Width of config registers

    localparam logic [coordW-1:0] xMin = 9'd0;
    localparam logic [coordW-1:0] xMax = 9'd319;
    localparam logic [coordW-1:0] yMin = 9'd0;
    localparam logic [coordW-1:0] yMax = 9'd239;

    localparam logic [coordW-1:0] spriteW = 9'd26;
    localparam logic [coordW-1:0] spriteH = 9'd26;
    localparam logic [addrW-1:0] frameWords = addrW'(spriteW) * addrW'(spriteH);

    localparam logic [cfgW-1:0] divReset = 8'd4;     // Frame edges per move
    localparam logic [cfgW-1:0] stepReset = 8'd1;    // Pixels per move

    // Facing direction, also the frame group in sprite memory
    typedef enum logic [1:0] {
        dirDown = 2'd0,
        dirLeft = 2'd1,
        dirUp = 2'd2,
        dirRight = 2'd3
    } dir_t;

    // Reset corner, enemy centred at 100*(id+1), 60*(id+1)
    function automatic logic [coordW-1:0] startX(input int id);
        return coordW'(100 * (id + 1)) - spriteW / 2;
    endfunction

    function automatic logic [coordW-1:0] startY(input int id);
        return coordW'(60 * (id + 1)) - spriteH / 2;
    endfunction

endpackage

/* rtl/enemyStateIf.sv */
// State of one enemy as seen by the renderer
// Owned by exactly one chaser, read by the renderer only

interface enemyStateIf;

    logic [enemyPkg::coordW-1:0] xPos;   // Top left corner
    logic [enemyPkg::coordW-1:0] yPos;
    enemyPkg::dir_t dir;
    logic [1:0] step;                    // Walk step, picks animation frame

    modport owner (output xPos, yPos, dir, step);

    modport viewer (input xPos, yPos, dir, step);

endinterface

/* rtl/frameTick.sv */
// Turns the frame clock level into a one-cycle move tick
// frameClk may be asynchronous, it passes one sync flop
// moveTick rises 3 clocks after frameClk is first sampled high

module frameTick (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      frameClk,
    input  logic [enemyPkg::cfgW-1:0] divider,
    output logic                      moveTick
);

    logic syncQ;                              // Sampled frame clock
    logic prevQ;
    logic edgeQ;                              // Registered rising edge
    logic lastEdge;                           // Divider-th edge seen
    logic [enemyPkg::cfgW-1:0] edgeCnt;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            syncQ <= 1'b0;
            prevQ <= 1'b0;
            edgeQ <= 1'b0;
            lastEdge <= 1'b0;
            edgeCnt <= '0;
            moveTick <= 1'b0;
        end else begin
            syncQ <= frameClk;
            prevQ <= syncQ;
            edgeQ <= syncQ & ~prevQ;
            lastEdge <= 1'b0;
            moveTick <= lastEdge;
            if (edgeQ) begin
                // Wrap also when divider dropped below the count
                if ({1'b0, edgeCnt} + 9'd1 >= {1'b0, divider}) begin
                    edgeCnt <= '0;
                    lastEdge <= 1'b1;
                end else begin
                    edgeCnt <= edgeCnt + 8'd1;
                end
            end
        end
    end

endmodule

/* rtl/spriteRender.sv */
// Pixel hit test over all enemies, purely combinational
// Lowest enemy index wins where boxes overlap
// Outputs are all zero when no enemy covers the pixel

module spriteRender #(
    parameter int numEnemies = 3
) (
    input  logic [enemyPkg::coordW-1:0] pixelX,
    input  logic [enemyPkg::coordW-1:0] pixelY,
    enemyStateIf.viewer                 states [numEnemies],
    output logic                        isObj,
    output logic [1:0]                  objIndex,
    output logic [enemyPkg::addrW-1:0]  objAddress
);

    logic [numEnemies-1:0] hit;
    logic [enemyPkg::addrW-1:0] addr [numEnemies];

    for (genvar i = 0; i < numEnemies; i++) begin : perEnemy
        logic [enemyPkg::addrW-1:0] dx;            // Offset inside the sprite
        logic [enemyPkg::addrW-1:0] dy;
        logic [3:0] frame;

        assign hit[i] = (pixelX >= states[i].xPos)
                     && (pixelX < states[i].xPos + enemyPkg::spriteW)
                     && (pixelY >= states[i].yPos)
                     && (pixelY < states[i].yPos + enemyPkg::spriteH);

        assign dx = enemyPkg::addrW'(pixelX - states[i].xPos);
        assign dy = enemyPkg::addrW'(pixelY - states[i].yPos);

        // Standing frame on even steps, walk frames 1 and 2 on odd steps
        assign frame = states[i].step[0]
                     ? 4'(3 * states[i].dir) + 4'd1 + 4'(states[i].step[1])
                     : 4'(3 * states[i].dir);

        assign addr[i] = dx + dy * enemyPkg::addrW'(enemyPkg::spriteW)
                       + enemyPkg::frameWords * enemyPkg::addrW'(frame);
    end

    always_comb begin
        isObj = 1'b0;
        objIndex = 2'd0;
        objAddress = '0;
        // Walk down so the lowest index is applied last
        for (int i = numEnemies - 1; i >= 0; i--) begin
            if (hit[i]) begin
                isObj = 1'b1;
                objIndex = 2'(i);
                objAddress = addr[i];
            end
        end
    end

endmodule

/* rtl/walkAnimator.sv */
// Walk-step counter of one enemy
// Counts up while the enemy walks, back to 0 when it stands

module walkAnimator (
    input  logic       Clk,
    input  logic       arstN,
    input  logic       moveTick,
    input  logic       moved,
    output logic [1:0] step
);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            step <= 2'd0;
        end else if (moveTick) begin
            if (moved) begin
                step <= step + 2'd1;   // Cycles through 4 walk phases
            end else begin
                step <= 2'd0;          // Standing frame
            end
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the enemyField testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module enemyFieldTb \
    -o enemyFieldSim

./obj_dir/enemyFieldSim 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

/* sources.f */
rtl/enemyPkg.sv
rtl/enemyStateIf.sv
rtl/chaseConfig.sv
rtl/frameTick.sv
rtl/walkAnimator.sv
rtl/enemyChaser.sv
rtl/spriteRender.sv
rtl/enemyField.sv
testbench/enemyField_chk.sv
testbench/enemyFieldTb.sv

/* testbench/enemyFieldTb.sv */
// Testbench for enemyField with three enemies
// One frame is a single frameClk pulse followed by one model step
// Expected values come from the chase, walk and render rules of the design
// Enemies stay clear of the left and top screen edges in every phase

module enemyFieldTb;

    localparam int numEnemies = 3;
    localparam int sprW = 26;
    localparam int sprH = 26;
    localparam int screenRight = 319;
    localparam int screenBottom = 239;
    localparam int numFrames = 226;                  // 4 + 12 + 10 + 100 + 100
    localparam int cycleLimit = 2 * numFrames * 10 + 200;

    logic Clk = 1'b0;
    logic arstN;
    logic frameClk;
    logic [8:0] playerX;
    logic [8:0] playerY;
    logic [8:0] pixelX;
    logic [8:0] pixelY;
    logic cfgWrite;
    logic cfgAddr;
    logic [7:0] cfgData;
    logic isObj;
    logic [1:0] objIndex;
    logic [12:0] objAddress;

    // Reference model state
    logic [8:0] mx [numEnemies];
    logic [8:0] my [numEnemies];
    logic [1:0] mdir [numEnemies];
    logic [1:0] mstep [numEnemies];
    int edgeCount;
    int modelDiv;
    logic [7:0] modelStep;

    logic checkReq;                                  // Probe pending for the compare process
    logic expObj;
    logic [1:0] expIdx;
    logic [12:0] expAddr;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    enemyField #(.numEnemies(numEnemies)) uut (
        .Clk       (Clk),
        .arstN     (arstN),
        .frameClk  (frameClk),
        .playerX   (playerX),
        .playerY   (playerY),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .cfgWrite  (cfgWrite),
        .cfgAddr   (cfgAddr),
        .cfgData   (cfgData),
        .isObj     (isObj),
        .objIndex  (objIndex),
        .objAddress(objAddress)
    );

    always #10 Clk = ~Clk;

    // Next {x, y, dir, step} of one enemy after a move tick
    function automatic logic [21:0] chaseStep(input logic [8:0] x, input logic [8:0] y,
                                              input logic [1:0] d, input logic [1:0] s,
                                              input logic [8:0] px, input logic [8:0] py,
                                              input logic [7:0] sz);
        logic [8:0] nx;
        logic [8:0] ny;
        logic [1:0] nd;
        logic moved;
        nx = x;
        ny = y;
        nd = d;
        moved = 1'b0;
        if (x < px) begin
            nd = 2'd3;                               // Right
            if (int'(x) + sprW < screenRight) begin
                nx = x + 9'(sz);
                moved = 1'b1;
            end
        end else if (x > px) begin
            nd = 2'd1;                               // Left
            if (x > 9'd0) begin
                nx = x - 9'(sz);
                moved = 1'b1;
            end
        end else if (y < py) begin
            nd = 2'd0;                               // Down
            if (int'(y) + sprH < screenBottom) begin
                ny = y + 9'(sz);
                moved = 1'b1;
            end
        end else if (y > py) begin
            nd = 2'd2;                               // Up
            if (y > 9'd0) begin
                ny = y - 9'(sz);
                moved = 1'b1;
            end
        end
        return {nx, ny, nd, (moved ? s + 2'd1 : 2'd0)};
    endfunction

    // Expected {isObj, objIndex, objAddress} for one pixel where the first hit wins
    function automatic logic [15:0] renderRef(input logic [8:0] px, input logic [8:0] py);
        int dx;
        int dy;
        int frame;
        logic [15:0] res;
        logic found;
        res = '0;
        found = 1'b0;
        for (int i = 0; i < numEnemies; i++) begin
            dx = int'(px) - int'(mx[i]);
            dy = int'(py) - int'(my[i]);
            if (!found && dx >= 0 && dx < sprW && dy >= 0 && dy < sprH) begin
                found = 1'b1;
                frame = 3 * int'(mdir[i]);
                if (mstep[i][0]) begin
                    frame = frame + 1 + int'(mstep[i][1]);   // Walk frames
                end
                res = {1'b1, 2'(i), 13'(dx + dy * sprW + sprW * sprH * frame)};
            end
        end
        return res;
    endfunction

    task automatic nextCycle();
        @(posedge Clk);
        #2;
    endtask

    // One probe per cycle and checked at the falling edge
    task automatic probe(input logic [8:0] px, input logic [8:0] py);
        logic [15:0] e;
        e = renderRef(px, py);
        pixelX = px;
        pixelY = py;
        {expObj, expIdx, expAddr} = e;
        checkReq = 1'b1;
        nextCycle();
        checkReq = 1'b0;
    endtask

    task automatic probeEnemies();
        int k;
        for (int i = 0; i < numEnemies; i++) begin
            probe(mx[i], my[i]);                     // Corner gives the frame base
            probe(mx[i] - 9'd1, my[i]);
        end
        repeat (2) begin
            k = int'($urandom_range(numEnemies - 1, 0));
            probe(mx[k] + 9'($urandom_range(sprW - 1, 0)),
                  my[k] + 9'($urandom_range(sprH - 1, 0)));
        end
        repeat (2) begin
            probe(9'($urandom_range(screenRight, 0)), 9'($urandom_range(screenBottom, 0)));
        end
    endtask

    // Frame clock high for 4 cycles and low for 6 before the model steps
    task automatic runFrame();
        logic [21:0] nxt;
        frameClk = 1'b1;
        repeat (4) nextCycle();
        frameClk = 1'b0;
        repeat (6) nextCycle();
        edgeCount = edgeCount + 1;
        if (edgeCount >= modelDiv) begin
            edgeCount = 0;
            for (int i = 0; i < numEnemies; i++) begin
                nxt = chaseStep(mx[i], my[i], mdir[i], mstep[i], playerX, playerY, modelStep);
                {mx[i], my[i], mdir[i], mstep[i]} = nxt;
            end
        end
        probeEnemies();
    endtask

    always @(negedge Clk) begin
        if (checkReq) begin
            checks = checks + 1;
            assert (isObj === expObj) else begin
                errors = errors + 1;
                $display("[ERROR] isObj: got 0x%h, expected 0x%h (pixel 0x%h, 0x%h)",
                         isObj, expObj, pixelX, pixelY);
            end
            assert (objIndex === expIdx) else begin
                errors = errors + 1;
                $display("[ERROR] objIndex: got 0x%h, expected 0x%h (pixel 0x%h, 0x%h)",
                         objIndex, expIdx, pixelX, pixelY);
            end
            assert (objAddress === expAddr) else begin
                errors = errors + 1;
                $display("[ERROR] objAddress: got 0x%h, expected 0x%h (pixel 0x%h, 0x%h)",
                         objAddress, expAddr, pixelX, pixelY);
            end
        end
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout: no result after %0d clock cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd121));
        for (int i = 0; i < numEnemies; i++) begin
            mx[i] = 9'(100 * (i + 1) - sprW / 2);    // Start corners
            my[i] = 9'(60 * (i + 1) - sprH / 2);
            mdir[i] = 2'd0;
            mstep[i] = 2'd0;
        end
        edgeCount = 0;
        modelDiv = 4;
        modelStep = 8'd1;
        arstN = 1'b1;
        frameClk = 1'b0;
        playerX = mx[0];                             // Player on enemy 0
        playerY = my[0];
        pixelX = 9'd0;
        pixelY = 9'd0;
        cfgWrite = 1'b0;
        cfgAddr = 1'b0;
        cfgData = 8'd0;
        checkReq = 1'b0;
        expObj = 1'b0;
        expIdx = 2'd0;
        expAddr = 13'd0;
        #2;
        arstN = 1'b0;
        repeat (3) nextCycle();
        arstN = 1'b1;

        probeEnemies();
        repeat (4) runFrame();

        // Default pace with a wandering player
        repeat (12) begin
            playerX = 9'($urandom_range(screenRight, 0));
            playerY = 9'($urandom_range(screenBottom, 0));
            runFrame();
        end

        cfgWrite = 1'b1;
        cfgAddr = 1'b0;
        cfgData = 8'd1;
        nextCycle();
        cfgAddr = 1'b1;
        cfgData = 8'd3;
        nextCycle();
        cfgWrite = 1'b0;
        modelDiv = 1;
        modelStep = 8'd3;
        playerX = 9'($urandom_range(260, 60));
        playerY = 9'($urandom_range(190, 40));
        repeat (10) runFrame();

        // Player in the far corner so enemies pile up at the right edge and stand
        playerX = 9'd319;
        playerY = 9'd239;
        repeat (100) runFrame();

        // Single steps onto enemy 1 until the boxes overlap and priority decides
        cfgWrite = 1'b1;
        cfgAddr = 1'b1;
        cfgData = 8'd1;
        nextCycle();
        cfgWrite = 1'b0;
        modelStep = 8'd1;
        playerX = mx[1];
        playerY = my[1];
        repeat (100) runFrame();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* testbench/enemyField_chk.sv */
// Concurrent checks on the enemyField top level
// Address bound assumes 12 frames of 26x26 words

module enemyFieldChk (
    input logic                       Clk,
    input logic                       arstN,
    input logic                       moveTick,
    input logic                       isObj,
    input logic [enemyPkg::addrW-1:0] objAddress,
    input logic [enemyPkg::cfgW-1:0]  divider,
    input logic [enemyPkg::cfgW-1:0]  stepSize
);

    tickPulse: assert property (@(posedge Clk) disable iff (!arstN) moveTick |=> !moveTick)
        else $error("moveTick stayed high for two cycles");

    // Address is zero when nothing is hit
    quietAddr: assert property (@(posedge Clk) !isObj |-> objAddress == '0)
        else $error("objAddress nonzero without a hit");

    addrRange: assert property (@(posedge Clk) objAddress < 13'd8112)
        else $error("objAddress beyond the sprite memory");

    resetCfg: assert property (@(posedge Clk) !arstN |-> (divider == 8'd4 && stepSize == 8'd1))
        else $error("config registers left their reset values during reset");

endmodule

bind enemyField enemyFieldChk chk (
    .Clk       (Clk),
    .arstN     (arstN),
    .moveTick  (moveTick),
    .isObj     (isObj),
    .objAddress(objAddress),
    .divider   (divider),
    .stepSize  (stepSize)
);
